/* flist.f */
+incdir+include
src/xrm_pkg.sv
src/xrm_axil_regs.sv
src/revo_frame_tracker.sv
src/bunch_marker_matcher.sv
src/trigger_prescaler.sv
src/xrm_trigger_top.sv
testbench/xrm_trigger_tb.sv

/* include/xrm_config.svh */
`ifndef XRM_CONFIG_SVH
`define XRM_CONFIG_SVH

// frame geometry
`define XRM_BUCKET_W        11
`define XRM_REVS_PER_FRAME  9

`define XRM_PRESCALE_W      5
`define XRM_COUNT_W         32
`define XRM_ADDR_W          5

// register map, byte addresses
`define XRM_REG_CTRL        5'h00
`define XRM_REG_MARKER_A    5'h04
`define XRM_REG_MARKER_B    5'h08
`define XRM_REG_MARKER_C    5'h0c
`define XRM_REG_MARKER_D    5'h10
`define XRM_REG_TRIG_COUNT  5'h14
`define XRM_REG_REVO_COUNT  5'h18

`endif

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and judge the run from its log
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module xrm_trigger_tb -f flist.f \
	&& ./obj_dir/Vxrm_trigger_tb > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
grep -q "TEST PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

/* src/bunch_marker_matcher.sv */
`timescale 1ns/1ns

module bunch_marker_matcher (
	input  logic                   clock127,
	input  logic                   arst_n,
	input  xrm_pkg::frame_pos_t    pos,
	input  xrm_pkg::marker_t [3:0] markers,
	output logic                   candidate
);
	logic [3:0] hit;

	// empty mask never matches
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			hit[i] = (markers[i].bucket == pos.bucket) && markers[i].rev_mask[pos.revolution];
		end
	end

	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n)
			candidate <= 1'b0;
		else
			candidate <= |hit;
	end

endmodule

/* src/revo_frame_tracker.sv */
`timescale 1ns/1ns
`include "xrm_config.svh"

module revo_frame_tracker (
	input  logic                clock127,
	input  logic                arst_n,
	input  logic                revo,
	output xrm_pkg::frame_pos_t pos,
	output xrm_pkg::count_t     revo_count
);
	localparam xrm_pkg::rev_t LAST_REV = xrm_pkg::rev_t'(`XRM_REVS_PER_FRAME - 1);
	localparam xrm_pkg::bucket_t LAST_BUCKET = '1;

	logic rev_wrap;

	assign rev_wrap = (pos.revolution == LAST_REV);

	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			pos.bucket <= '0;
			pos.revolution <= LAST_REV; // first revo lands on revolution 0
			pos.frame <= 1'b0;
			pos.frame9 <= 1'b0;
			revo_count <= '0;
		end else begin
			pos.frame <= revo;
			pos.frame9 <= revo && rev_wrap;
			if (revo) begin
				pos.bucket <= '0;
				pos.revolution <= rev_wrap ? '0 : pos.revolution + 1'b1;
				revo_count <= revo_count + 1'b1;
			end else if (pos.bucket != LAST_BUCKET) begin
				pos.bucket <= pos.bucket + 1'b1; // sticks at max if revo goes missing
			end
		end
	end

endmodule

/* src/trigger_prescaler.sv */
`timescale 1ns/1ns

module trigger_prescaler (
	input  logic                clock127,
	input  logic                arst_n,
	input  logic                candidate,
	input  logic                enable,
	input  xrm_pkg::prescale_t  prescale_log2,
	output logic                xrm_trigger,
	output xrm_pkg::count_t     trig_count
);
	xrm_pkg::count_t cand_count;
	xrm_pkg::count_t low_mask;
	logic pass;

	assign low_mask = (xrm_pkg::count_t'(1) << prescale_log2) - 1'b1;
	// first candidate after enable gets through
	assign pass = enable && candidate && ((cand_count & low_mask) == '0);

	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			cand_count <= '0;
			xrm_trigger <= 1'b0;
			trig_count <= '0;
		end else begin
			if (!enable)
				cand_count <= '0;
			else if (candidate)
				cand_count <= cand_count + 1'b1;
			xrm_trigger <= pass;
			if (pass)
				trig_count <= trig_count + 1'b1;
		end
	end

endmodule

/* src/xrm_axil_regs.sv */
`timescale 1ns/1ns
`include "xrm_config.svh"

module xrm_axil_regs (
	input  logic               clock127,
	input  logic               arst_n,
	input  xrm_pkg::axil_req_t axil_req,
	output xrm_pkg::axil_rsp_t axil_rsp,
	output xrm_pkg::xrm_cfg_t  cfg,
	input  xrm_pkg::count_t    trig_count,
	input  xrm_pkg::count_t    revo_count
);
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	xrm_pkg::axil_state_e state;
	logic rd_take;
	logic wr_take;
	logic [31:0] wr_old;
	logic [31:0] wr_new;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic [1:0] bresp;

	// marker fields sit where the board firmware expects them
	function automatic logic [31:0] marker_image(input xrm_pkg::marker_t m);
		logic [31:0] img;
		img = '0;
		img[12:2] = m.bucket;
		img[24:16] = m.rev_mask;
		return img;
	endfunction

	function automatic logic [31:0] reg_image(input logic [`XRM_ADDR_W-1:0] addr);
		logic [31:0] img;
		img = '0;
		case (addr)
			`XRM_REG_CTRL: begin
				img[0] = cfg.enable;
				img[12:8] = cfg.prescale_log2;
			end
			`XRM_REG_MARKER_A: img = marker_image(cfg.markers[0]);
			`XRM_REG_MARKER_B: img = marker_image(cfg.markers[1]);
			`XRM_REG_MARKER_C: img = marker_image(cfg.markers[2]);
			`XRM_REG_MARKER_D: img = marker_image(cfg.markers[3]);
			`XRM_REG_TRIG_COUNT: img = trig_count;
			`XRM_REG_REVO_COUNT: img = revo_count;
			default: img = '0;
		endcase
		return img;
	endfunction

	function automatic logic addr_mapped(input logic [`XRM_ADDR_W-1:0] addr);
		case (addr)
			`XRM_REG_CTRL, `XRM_REG_MARKER_A, `XRM_REG_MARKER_B, `XRM_REG_MARKER_C,
			`XRM_REG_MARKER_D, `XRM_REG_TRIG_COUNT, `XRM_REG_REVO_COUNT: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// read wins when both arrive together
	assign rd_take = (state == xrm_pkg::IDLE) && axil_req.arvalid;
	assign wr_take = (state == xrm_pkg::IDLE) && !axil_req.arvalid
		&& axil_req.awvalid && axil_req.wvalid;

	always_comb begin
		wr_old = reg_image(axil_req.awaddr);
		for (int i = 0; i < 4; i++) begin
			wr_new[8*i +: 8] = axil_req.wstrb[i] ? axil_req.wdata[8*i +: 8] : wr_old[8*i +: 8];
		end
	end

	assign axil_rsp.awready = wr_take;
	assign axil_rsp.wready = wr_take;
	assign axil_rsp.bvalid = (state == xrm_pkg::WRITE_RESP);
	assign axil_rsp.bresp = bresp;
	assign axil_rsp.arready = rd_take;
	assign axil_rsp.rvalid = (state == xrm_pkg::READ_RESP);
	assign axil_rsp.rdata = rdata;
	assign axil_rsp.rresp = rresp;

	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			state <= xrm_pkg::IDLE;
		end else begin
			case (state)
				xrm_pkg::IDLE: begin
					if (rd_take)
						state <= xrm_pkg::READ_RESP;
					else if (wr_take)
						state <= xrm_pkg::WRITE_RESP;
				end
				xrm_pkg::WRITE_RESP: if (axil_req.bready) state <= xrm_pkg::IDLE;
				xrm_pkg::READ_RESP: if (axil_req.rready) state <= xrm_pkg::IDLE;
				default: state <= xrm_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			cfg <= '0;
		end else if (wr_take) begin
			case (axil_req.awaddr)
				`XRM_REG_CTRL: begin
					cfg.enable <= wr_new[0];
					cfg.prescale_log2 <= wr_new[12:8];
				end
				`XRM_REG_MARKER_A: cfg.markers[0] <= {wr_new[12:2], wr_new[24:16]};
				`XRM_REG_MARKER_B: cfg.markers[1] <= {wr_new[12:2], wr_new[24:16]};
				`XRM_REG_MARKER_C: cfg.markers[2] <= {wr_new[12:2], wr_new[24:16]};
				`XRM_REG_MARKER_D: cfg.markers[3] <= {wr_new[12:2], wr_new[24:16]};
				default: ; // counters are read only
			endcase
		end
	end

	// response payload, held until the handshake
	always_ff @(posedge clock127) begin
		if (rd_take) begin
			rdata <= reg_image(axil_req.araddr);
			rresp <= addr_mapped(axil_req.araddr) ? RESP_OKAY : RESP_SLVERR;
		end
		if (wr_take)
			bresp <= addr_mapped(axil_req.awaddr) ? RESP_OKAY : RESP_SLVERR;
	end

endmodule

/* src/xrm_pkg.sv */
`include "xrm_config.svh"

package xrm_pkg;

	typedef logic [`XRM_BUCKET_W-1:0] bucket_t;
	typedef logic [$clog2(`XRM_REVS_PER_FRAME)-1:0] rev_t;
	typedef logic [`XRM_REVS_PER_FRAME-1:0] rev_mask_t; // one bit per revolution
	typedef logic [`XRM_PRESCALE_W-1:0] prescale_t;
	typedef logic [`XRM_COUNT_W-1:0] count_t;

	typedef struct packed {
		bucket_t bucket;
		rev_mask_t rev_mask;
	} marker_t;

	typedef struct packed {
		logic enable;
		prescale_t prescale_log2;
		marker_t [3:0] markers; // a is index 0
	} xrm_cfg_t;

	typedef struct packed {
		bucket_t bucket;
		rev_t revolution;
		logic frame;
		logic frame9;
	} frame_pos_t;

	typedef struct packed {
		logic awvalid;
		logic [`XRM_ADDR_W-1:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic bready;
		logic arvalid;
		logic [`XRM_ADDR_W-1:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

	typedef enum logic [1:0] {
		IDLE,
		WRITE_RESP,
		READ_RESP
	} axil_state_e;

endpackage

/* src/xrm_trigger_top.sv */
`timescale 1ns/1ns

module xrm_trigger_top (
	input  logic               clock127,
	input  logic               arst_n,
	input  logic               revo,
	input  xrm_pkg::axil_req_t axil_req,
	output xrm_pkg::axil_rsp_t axil_rsp,
	output logic               xrm_trigger,
	output logic               frame,
	output logic               frame9
);
	xrm_pkg::xrm_cfg_t cfg;
	xrm_pkg::frame_pos_t pos;
	xrm_pkg::count_t trig_count;
	xrm_pkg::count_t revo_count;
	logic candidate;

	xrm_axil_regs xrm_axil_regs_inst (
		.clock127   (clock127),
		.arst_n     (arst_n),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.cfg        (cfg),
		.trig_count (trig_count),
		.revo_count (revo_count)
	);

	revo_frame_tracker revo_frame_tracker_inst (
		.clock127   (clock127),
		.arst_n     (arst_n),
		.revo       (revo),
		.pos        (pos),
		.revo_count (revo_count)
	);

	bunch_marker_matcher bunch_marker_matcher_inst (
		.clock127  (clock127),
		.arst_n    (arst_n),
		.pos       (pos),
		.markers   (cfg.markers),
		.candidate (candidate)
	);

	trigger_prescaler trigger_prescaler_inst (
		.clock127      (clock127),
		.arst_n        (arst_n),
		.candidate     (candidate),
		.enable        (cfg.enable),
		.prescale_log2 (cfg.prescale_log2),
		.xrm_trigger   (xrm_trigger),
		.trig_count    (trig_count)
	);

	assign frame = pos.frame;
	assign frame9 = pos.frame9;

endmodule

/* testbench/xrm_trigger_tb.sv */
`timescale 1ns/1ns
`include "xrm_config.svh"

module xrm_trigger_tb;
	localparam int WAIT_LIMIT = 50;
	localparam logic [1:0] OKAY = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	logic clock127;
	logic arst_n;
	logic revo;
	xrm_pkg::axil_req_t axil_req;
	xrm_pkg::axil_rsp_t axil_rsp;
	logic xrm_trigger;
	logic frame;
	logic frame9;

	logic [31:0] exp_reg [5]; // ctrl, then markers a to d, as read back
	xrm_pkg::bucket_t m_bucket;
	xrm_pkg::rev_t m_rev;
	longint m_cands;
	logic exp_frame;
	logic exp_frame9;
	logic exp_cand;
	logic exp_trig;
	int revo_sent;
	int trig_seen;
	int aw_beats;
	int w_beats;
	int ar_beats;
	int errors;
	int errors_at_start;
	int tests_run;
	int tests_failed;

	xrm_trigger_top xrm_trigger_top_inst (
		.clock127    (clock127),
		.arst_n      (arst_n),
		.revo        (revo),
		.axil_req    (axil_req),
		.axil_rsp    (axil_rsp),
		.xrm_trigger (xrm_trigger),
		.frame       (frame),
		.frame9      (frame9)
	);

	initial begin
		clock127 = 1'b0;
		forever #10 clock127 = ~clock127;
	end

	function automatic logic marker_hit(input xrm_pkg::bucket_t bucket, input xrm_pkg::rev_t rev);
		logic hit;
		hit = 1'b0;
		for (int i = 1; i <= 4; i++) begin
			if (exp_reg[i][12:2] == bucket && exp_reg[i][16 + rev])
				hit = 1'b1;
		end
		return hit;
	endfunction

	// reference model, fed by the testbench's own revo
	always @(posedge clock127 or negedge arst_n) begin
		if (!arst_n) begin
			m_bucket <= '0;
			m_rev <= 4'd8;
			m_cands <= 0;
			exp_frame <= 1'b0;
			exp_frame9 <= 1'b0;
			exp_cand <= 1'b0;
			exp_trig <= 1'b0;
		end else begin
			exp_frame <= revo;
			exp_frame9 <= revo && (m_rev == 4'd8);
			if (revo) begin
				m_bucket <= '0;
				m_rev <= (m_rev == 4'd8) ? 4'd0 : m_rev + 4'd1;
			end else if (m_bucket != '1) begin
				m_bucket <= m_bucket + 11'd1;
			end
			exp_cand <= marker_hit(m_bucket, m_rev);
			exp_trig <= exp_reg[0][0] && exp_cand && (m_cands % (64'd1 << exp_reg[0][12:8])) == 0;
			if (!exp_reg[0][0])
				m_cands <= 0;
			else if (exp_cand)
				m_cands <= m_cands + 1;
		end
	end

	frame_check: assert property (@(posedge clock127) disable iff (!arst_n) frame == exp_frame)
		else begin
			$display("FAILED at %0t: frame pulse does not follow revo by one cycle", $time);
			errors++;
		end
	frame9_check: assert property (@(posedge clock127) disable iff (!arst_n) frame9 == exp_frame9)
		else begin
			$display("FAILED at %0t: frame9 pulse off the ninth revolution", $time);
			errors++;
		end
	trigger_check: assert property (@(posedge clock127) disable iff (!arst_n)
		xrm_trigger == exp_trig)
		else begin
			$display("FAILED at %0t: xrm_trigger differs from the predicted pulse", $time);
			errors++;
		end

	always @(negedge clock127) begin
		if (arst_n && xrm_trigger)
			trig_seen++;
	end

	// beats the slave accepted, counted on the handshake edge
	always @(posedge clock127) begin
		if (arst_n && axil_req.awvalid && axil_rsp.awready)
			aw_beats++;
		if (arst_n && axil_req.wvalid && axil_rsp.wready)
			w_beats++;
		if (arst_n && axil_req.arvalid && axil_rsp.arready)
			ar_beats++;
	end

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
		assert (got == want)
			else begin
				$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
				errors++;
			end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic store_expected(input logic [4:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		int idx;
		idx = addr >> 2;
		if (addr[1:0] == 2'b00 && idx <= 4) begin
			for (int b = 0; b < 4; b++)
				if (strb[b])
					exp_reg[idx][8*b +: 8] = data[8*b +: 8];
			exp_reg[idx] &= (idx == 0) ? 32'h0000_1f01 : 32'h01ff_1ffc; // fields only
		end
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input logic [1:0] want_resp, input int stall);
		int n;
		int aw_before;
		int w_before;
		aw_before = aw_beats;
		w_before = w_beats;
		@(negedge clock127);
		axil_req.awvalid = 1'b1;
		axil_req.awaddr = addr;
		axil_req.wvalid = 1'b1;
		axil_req.wdata = data;
		axil_req.wstrb = strb;
		n = 0;
		do begin
			@(negedge clock127);
			n++;
		end while (!axil_rsp.bvalid && n < WAIT_LIMIT);
		if (!axil_rsp.bvalid) begin
			abort_on_timeout("write response");
		end else begin
			axil_req.awvalid = 1'b0;
			axil_req.wvalid = 1'b0;
			store_expected(addr, data, strb); // dut register took it at the handshake edge
			repeat (stall) begin
				@(negedge clock127);
				check_value("bvalid under back-pressure", 32'(axil_rsp.bvalid), 32'd1);
			end
			check_value("bresp", 32'(axil_rsp.bresp), 32'(want_resp));
			axil_req.bready = 1'b1;
			@(negedge clock127);
			axil_req.bready = 1'b0;
			check_value("bvalid after handshake", 32'(axil_rsp.bvalid), 32'd0);
			check_value("write address beats", 32'(aw_beats - aw_before), 32'd1);
			check_value("write data beats", 32'(w_beats - w_before), 32'd1);
		end
	endtask

	task automatic expect_read(input logic [4:0] addr, input logic [31:0] want,
			input logic [1:0] want_resp, input int stall);
		int n;
		int ar_before;
		ar_before = ar_beats;
		@(negedge clock127);
		axil_req.arvalid = 1'b1;
		axil_req.araddr = addr;
		n = 0;
		do begin
			@(negedge clock127);
			n++;
		end while (!axil_rsp.rvalid && n < WAIT_LIMIT);
		if (!axil_rsp.rvalid) begin
			abort_on_timeout("read response");
		end else begin
			axil_req.arvalid = 1'b0;
			repeat (stall) begin
				@(negedge clock127);
				check_value("rvalid under back-pressure", 32'(axil_rsp.rvalid), 32'd1);
			end
			check_value("rdata", axil_rsp.rdata, want);
			check_value("rresp", 32'(axil_rsp.rresp), 32'(want_resp));
			axil_req.rready = 1'b1;
			@(negedge clock127);
			axil_req.rready = 1'b0;
			check_value("rvalid after handshake", 32'(axil_rsp.rvalid), 32'd0);
			check_value("read address beats", 32'(ar_beats - ar_before), 32'd1);
		end
	endtask

	task automatic run_revolutions(input int count);
		int len;
		for (int r = 0; r < count; r++) begin
			len = 40 + ($urandom % 81); // buckets in this revolution
			@(negedge clock127);
			revo = 1'b1;
			revo_sent++;
			@(negedge clock127);
			revo = 1'b0;
			repeat (len - 2) @(negedge clock127);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	initial begin
		int trig_before;
		void'($urandom(32'h4651_57a7));
		arst_n = 1'b0;
		revo = 1'b0;
		axil_req = '0;
		revo_sent = 0;
		trig_seen = 0;
		aw_beats = 0;
		w_beats = 0;
		ar_beats = 0;
		errors = 0;
		errors_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < 5; i++)
			exp_reg[i] = '0;
		repeat (3) @(negedge clock127);
		arst_n = 1'b1;

		write_reg(`XRM_REG_CTRL, 32'hffff_fe01, 4'hf, OKAY, 0);
		expect_read(`XRM_REG_CTRL, exp_reg[0], OKAY, 0);
		write_reg(`XRM_REG_MARKER_A, 32'hfea3_eabf, 4'hf, OKAY, 0);
		expect_read(`XRM_REG_MARKER_A, exp_reg[1], OKAY, 0);
		write_reg(`XRM_REG_MARKER_A, 32'hffff_ffff, 4'b0100, OKAY, 0); // mask low byte only
		expect_read(`XRM_REG_MARKER_A, 32'h00ff_0abc, OKAY, 0);
		write_reg(5'h1c, 32'hffff_ffff, 4'hf, SLVERR, 0);
		expect_read(5'h1c, 32'h0, SLVERR, 0);
		expect_read(`XRM_REG_MARKER_C, exp_reg[3], OKAY, 0);
		end_test("axi access");

		run_revolutions(20);
		expect_read(`XRM_REG_REVO_COUNT, revo_sent, OKAY, 0);
		end_test("framing");

		write_reg(`XRM_REG_MARKER_A, 32'h01ff_0000, 4'hf, OKAY, 0); // bucket 0, all revolutions
		write_reg(`XRM_REG_MARKER_B, 32'h0001_0008, 4'hf, OKAY, 0);
		write_reg(`XRM_REG_MARKER_C, 32'h0100_000c, 4'hf, OKAY, 0);
		write_reg(`XRM_REG_MARKER_D, 32'h0038_0010, 4'hf, OKAY, 0);
		write_reg(`XRM_REG_CTRL, 32'h0000_0001, 4'hf, OKAY, 0);
		trig_before = trig_seen;
		run_revolutions(20);
		check_value("enough triggers", 32'(trig_seen - trig_before >= 20), 32'd1);
		end_test("marker matching");

		write_reg(`XRM_REG_CTRL, 32'h0000_0000, 4'hf, OKAY, 0); // clears the candidate count
		write_reg(`XRM_REG_CTRL, 32'h0000_0201, 4'hf, OKAY, 0);
		trig_before = trig_seen;
		run_revolutions(20);
		check_value("enough prescaled triggers", 32'(trig_seen - trig_before >= 5), 32'd1);
		end_test("prescaling");

		write_reg(`XRM_REG_CTRL, 32'h0000_0000, 4'hf, OKAY, 4);
		trig_before = trig_seen;
		run_revolutions(10);
		check_value("triggers while disabled", trig_seen - trig_before, 32'd0);
		expect_read(`XRM_REG_TRIG_COUNT, trig_seen, OKAY, 5);
		expect_read(`XRM_REG_REVO_COUNT, revo_sent, OKAY, 3);
		end_test("enable and status");

		$display("%0d tests run, %0d failed, %0d failed checks", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
